// ==== source/dma_cfg.svh ====
// Width, depth and register map macros for the DMA request table, included by the package and RTL
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// Register port widths
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Descriptor table depth and index width
// Index comes from address bits 6 down to 5
`define DMA_TABLE_ENTRIES 4
`define DMA_PTR_WIDTH 2

// Number of writable words in one entry window
`define DMA_REQMASK_WIDTH 5

// Descriptor field widths
`define DMA_LADDR_WIDTH 32
`define DMA_SIZE_WIDTH 16
`define DMA_RTILE_WIDTH 8
`define DMA_RADDR_WIDTH 32

// Word offsets inside a 32-byte entry window
`define DMA_WORD_LADDR 0
`define DMA_WORD_SIZE 1
`define DMA_WORD_RTILE 2
`define DMA_WORD_RADDR 3
`define DMA_WORD_DIR 4
// Status word sits at byte offset 0x14
`define DMA_STATUS_OFFSET 5

// Byte step between consecutive beats
`define DMA_BEAT_STRIDE 4

`endif

// ==== source/dma_pkg.sv ====
// Shared descriptor and select types for the DMA request table, imported by every RTL module
`include "dma_cfg.svh"

package dma_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Transfer descriptor
  ////////////////////////////////////////////////////////////////////////////

  // One table entry as software writes it
  // Field order matches the word order of the register window
  typedef struct packed {
    // Word 0, local start address
    logic [`DMA_LADDR_WIDTH-1:0] laddr;
    // Word 1, transfer length in words
    logic [`DMA_SIZE_WIDTH-1:0]  size;
    // Word 2, destination tile
    logic [`DMA_RTILE_WIDTH-1:0] rtile;
    // Word 3, remote start address
    logic [`DMA_RADDR_WIDTH-1:0] raddr;
    // Word 4 bit 0, transfer direction
    logic                        dir;
  } dma_request_t;

  ////////////////////////////////////////////////////////////////////////////
  // Word select
  ////////////////////////////////////////////////////////////////////////////

  // One-hot mask of the descriptor word targeted by a register write
  // Bit n set means word n of the window
  // Status word has no bit here
  typedef logic [`DMA_REQMASK_WIDTH-1:0] dma_select_t;

endpackage

// ==== source/dma_bus_if.sv ====
// AHB-Lite style register decoder that turns bus accesses into table write, post and ack strobes
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_bus_if
  import dma_pkg::*;
(
  // Kept for a uniform port list with the other blocks
  input  logic                       clk,
  input  logic                       rst_n,

  // Register port
  input  logic [`DMA_ADDR_WIDTH-1:0] haddr,
  input  logic [`DMA_DATA_WIDTH-1:0] hwdata,
  input  logic                       hsel,
  input  logic                       hmastlock,
  input  logic                       hwrite,
  output logic [`DMA_DATA_WIDTH-1:0] hrdata,
  output logic                       hready,

  // Descriptor word write
  output logic                       write_en,
  output logic [`DMA_PTR_WIDTH-1:0]  write_pos,
  output dma_select_t                write_select,
  output logic [`DMA_DATA_WIDTH-1:0] write_data,

  // Status word strobes
  output logic                       post_en,
  output logic                       ack_en,

  // Completion flags from the table
  input  logic [`DMA_TABLE_ENTRIES-1:0] done_flags
);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  logic       access;
  logic [2:0] word_idx;
  logic       is_status;

  // hsel and hmastlock together qualify a cycle
  assign access = hsel & hmastlock;

  // No wait states so ready follows the qualify condition
  assign hready = access;

  // Entry index from the 32-byte window number
  assign write_pos = haddr[`DMA_PTR_WIDTH+4:5];

  // Word inside the window, byte lanes ignored
  assign word_idx  = haddr[4:2];
  assign is_status = (word_idx == 3'(`DMA_STATUS_OFFSET));

  // One-hot select for descriptor words 0 to 4
  // Status and unused offsets leave every bit low
  always_comb begin
    for (int i = 0; i < `DMA_REQMASK_WIDTH; i++) begin
      write_select[i] = (word_idx == 3'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////////////////////

  // Word write only when some descriptor word is hit
  assign write_en   = access & hwrite & (|write_select);
  assign write_data = hwdata;

  // Writing status posts the entry whatever the data
  assign post_en = access & hwrite & is_status;

  // Reading status acknowledges a finished entry
  assign ack_en  = access & ~hwrite & is_status;

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Done flag seen before the table clears it at the next edge
  // Every other read returns zero
  assign hrdata = {{(`DMA_DATA_WIDTH-1){1'b0}}, ack_en & done_flags[write_pos]};

endmodule

// ==== source/dma_request_table.sv ====
// Descriptor storage with per-entry valid and done flags, written by the bus interface
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_request_table
  import dma_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Descriptor word write from the register port
  input  logic                          write_en,
  input  logic [`DMA_PTR_WIDTH-1:0]     write_pos,
  input  dma_select_t                   write_select,
  input  logic [`DMA_DATA_WIDTH-1:0]    write_data,

  // Status strobes, indexed by write_pos
  input  logic                          post_en,
  input  logic                          ack_en,

  // Completion strobe from the engine
  input  logic                          finish_en,
  input  logic [`DMA_PTR_WIDTH-1:0]     finish_pos,

  // Stored descriptors and flags
  output dma_request_t                  entries [`DMA_TABLE_ENTRIES],
  output logic [`DMA_TABLE_ENTRIES-1:0] valid_flags,
  output logic [`DMA_TABLE_ENTRIES-1:0] done_flags
);

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor words
  ////////////////////////////////////////////////////////////////////////////

  // Payload storage only
  // Narrow fields keep the low bits of the written word
  always_ff @(posedge clk) begin
    if (write_en) begin
      if (write_select[`DMA_WORD_LADDR]) begin
        entries[write_pos].laddr <= write_data[`DMA_LADDR_WIDTH-1:0];
      end
      if (write_select[`DMA_WORD_SIZE]) begin
        entries[write_pos].size <= write_data[`DMA_SIZE_WIDTH-1:0];
      end
      if (write_select[`DMA_WORD_RTILE]) begin
        entries[write_pos].rtile <= write_data[`DMA_RTILE_WIDTH-1:0];
      end
      if (write_select[`DMA_WORD_RADDR]) begin
        entries[write_pos].raddr <= write_data[`DMA_RADDR_WIDTH-1:0];
      end
      if (write_select[`DMA_WORD_DIR]) begin
        entries[write_pos].dir <= write_data[0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid and done flags
  ////////////////////////////////////////////////////////////////////////////

  // Later statements win on the same entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_flags <= '0;
      done_flags  <= '0;
    end else begin
      // Status read clears done
      if (ack_en) begin
        done_flags[write_pos] <= 1'b0;
      end
      // Finish beats ack so a same-cycle read still sees done later
      if (finish_en) begin
        valid_flags[finish_pos] <= 1'b0;
        done_flags[finish_pos]  <= 1'b1;
      end
      // Posting arms the entry again
      if (post_en) begin
        valid_flags[write_pos] <= 1'b1;
        done_flags[write_pos]  <= 1'b0;
      end
    end
  end

endmodule

// ==== source/dma_transfer_engine.sv ====
// Round-robin scheduler that streams one address beat per descriptor word with stall handling
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_transfer_engine
  import dma_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,

  // Table view
  input  dma_request_t                  entries [`DMA_TABLE_ENTRIES],
  input  logic [`DMA_TABLE_ENTRIES-1:0] valid_flags,

  // Completion strobe back to the table
  output logic                          finish_en,
  output logic [`DMA_PTR_WIDTH-1:0]     finish_pos,

  // Beat stream
  output logic                          xfer_valid,
  output logic [`DMA_LADDR_WIDTH-1:0]   xfer_laddr,
  output logic [`DMA_RTILE_WIDTH-1:0]   xfer_rtile,
  output logic [`DMA_RADDR_WIDTH-1:0]   xfer_raddr,
  output logic                          xfer_dir,
  input  logic                          xfer_stall
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_STREAM,
    ST_FINISH
  } state_t;

  state_t                        state;
  // Last entry served, also the entry in flight
  logic [`DMA_PTR_WIDTH-1:0]     last_pos;
  dma_request_t                  desc_q;
  logic [`DMA_LADDR_WIDTH-1:0]   laddr_q;
  logic [`DMA_RADDR_WIDTH-1:0]   raddr_q;
  logic [`DMA_SIZE_WIDTH-1:0]    remaining;
  logic                          pick_found;
  logic [`DMA_PTR_WIDTH-1:0]     pick_pos;
  logic [`DMA_PTR_WIDTH-1:0]     cand;
  logic                          beat_take;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin search
  ////////////////////////////////////////////////////////////////////////////

  // Scan starts after last_pos and wraps back to it
  always_comb begin
    pick_found = 1'b0;
    pick_pos   = last_pos;
    cand       = last_pos;
    for (int i = 1; i <= `DMA_TABLE_ENTRIES; i++) begin
      cand = last_pos + `DMA_PTR_WIDTH'(i);
      if (!pick_found && valid_flags[cand]) begin
        pick_found = 1'b1;
        pick_pos   = cand;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  assign beat_take = (state == ST_STREAM) && !xfer_stall;

  // Reset value makes the first search start at entry 0
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      last_pos <= `DMA_PTR_WIDTH'(`DMA_TABLE_ENTRIES - 1);
    end else begin
      case (state)
        ST_IDLE: begin
          if (pick_found) begin
            last_pos <= pick_pos;
            state    <= ST_LOAD;
          end
        end
        // Zero-size entries skip straight to completion
        ST_LOAD:   state <= (desc_q.size == '0) ? ST_FINISH : ST_STREAM;
        ST_STREAM: begin
          if (beat_take && remaining == `DMA_SIZE_WIDTH'(1)) begin
            state <= ST_FINISH;
          end
        end
        default:   state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Descriptor copy and beat registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Snapshot the chosen entry
    if (state == ST_IDLE) begin
      desc_q <= entries[pick_pos];
    end
    // Seed address and word counters
    if (state == ST_LOAD) begin
      laddr_q   <= desc_q.laddr;
      raddr_q   <= desc_q.raddr;
      remaining <= desc_q.size;
    end
    // Step on every consumed beat, hold while stalled
    if (beat_take) begin
      laddr_q   <= laddr_q + `DMA_LADDR_WIDTH'(`DMA_BEAT_STRIDE);
      raddr_q   <= raddr_q + `DMA_RADDR_WIDTH'(`DMA_BEAT_STRIDE);
      remaining <= remaining - `DMA_SIZE_WIDTH'(1);
    end
  end

  assign xfer_valid = (state == ST_STREAM);
  assign xfer_laddr = laddr_q;
  assign xfer_raddr = raddr_q;
  assign xfer_rtile = desc_q.rtile;
  assign xfer_dir   = desc_q.dir;

  // One-cycle completion pulse for the entry in flight
  assign finish_en  = (state == ST_FINISH);
  assign finish_pos = last_pos;

endmodule

// ==== source/dma_ctrl_top.sv ====
// Top level of the DMA request table joining the register decoder, descriptor table and engine
`timescale 1ns/1ps
`include "dma_cfg.svh"

module dma_ctrl_top
  import dma_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,

  // Register port
  input  logic [`DMA_ADDR_WIDTH-1:0]  haddr,
  input  logic [`DMA_DATA_WIDTH-1:0]  hwdata,
  input  logic                        hsel,
  input  logic                        hmastlock,
  input  logic                        hwrite,
  output logic [`DMA_DATA_WIDTH-1:0]  hrdata,
  output logic                        hready,

  // Beat stream
  output logic                        xfer_valid,
  output logic [`DMA_LADDR_WIDTH-1:0] xfer_laddr,
  output logic [`DMA_RTILE_WIDTH-1:0] xfer_rtile,
  output logic [`DMA_RADDR_WIDTH-1:0] xfer_raddr,
  output logic                        xfer_dir,
  input  logic                        xfer_stall
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  // Bus interface to table
  logic                          write_en;
  logic [`DMA_PTR_WIDTH-1:0]     write_pos;
  dma_select_t                   write_select;
  logic [`DMA_DATA_WIDTH-1:0]    write_data;
  logic                          post_en;
  logic                          ack_en;

  // Table to bus interface and engine
  dma_request_t                  entries [`DMA_TABLE_ENTRIES];
  logic [`DMA_TABLE_ENTRIES-1:0] valid_flags;
  logic [`DMA_TABLE_ENTRIES-1:0] done_flags;

  // Engine to table
  logic                          finish_en;
  logic [`DMA_PTR_WIDTH-1:0]     finish_pos;

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  dma_bus_if u_bus_if (
    .clk          (clk),
    .rst_n        (rst_n),
    .haddr        (haddr),
    .hwdata       (hwdata),
    .hsel         (hsel),
    .hmastlock    (hmastlock),
    .hwrite       (hwrite),
    .hrdata       (hrdata),
    .hready       (hready),
    .write_en     (write_en),
    .write_pos    (write_pos),
    .write_select (write_select),
    .write_data   (write_data),
    .post_en      (post_en),
    .ack_en       (ack_en),
    .done_flags   (done_flags)
  );

  // Register block beside the engine it steers
  dma_request_table u_table (
    .clk          (clk),
    .rst_n        (rst_n),
    .write_en     (write_en),
    .write_pos    (write_pos),
    .write_select (write_select),
    .write_data   (write_data),
    .post_en      (post_en),
    .ack_en       (ack_en),
    .finish_en    (finish_en),
    .finish_pos   (finish_pos),
    .entries      (entries),
    .valid_flags  (valid_flags),
    .done_flags   (done_flags)
  );

  dma_transfer_engine u_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .entries      (entries),
    .valid_flags  (valid_flags),
    .finish_en    (finish_en),
    .finish_pos   (finish_pos),
    .xfer_valid   (xfer_valid),
    .xfer_laddr   (xfer_laddr),
    .xfer_rtile   (xfer_rtile),
    .xfer_raddr   (xfer_raddr),
    .xfer_dir     (xfer_dir),
    .xfer_stall   (xfer_stall)
  );

endmodule

// ==== verif/tb_dma_ctrl.sv ====
// Self-checking testbench for the DMA request table that runs as the simulation top from vlog.f
`timescale 1ns/1ps
`include "dma_cfg.svh"

module tb_dma_ctrl
  import dma_pkg::*;
();

  localparam int CLK_HALF     = 5;
  localparam int BEAT_STEP    = 4;
  localparam int STATUS_WORD  = 5;
  localparam int DONE_TIMEOUT = 400;

  // Address beat as seen on the stream outputs
  typedef struct packed {
    logic [`DMA_LADDR_WIDTH-1:0] laddr;
    logic [`DMA_RTILE_WIDTH-1:0] rtile;
    logic [`DMA_RADDR_WIDTH-1:0] raddr;
    logic                        dir;
  } beat_t;

  logic                        clk;
  logic                        rst_n;
  logic [`DMA_ADDR_WIDTH-1:0]  haddr;
  logic [`DMA_DATA_WIDTH-1:0]  hwdata;
  logic                        hsel;
  logic                        hmastlock;
  logic                        hwrite;
  logic [`DMA_DATA_WIDTH-1:0]  hrdata;
  logic                        hready;
  logic                        xfer_valid;
  logic [`DMA_LADDR_WIDTH-1:0] xfer_laddr;
  logic [`DMA_RTILE_WIDTH-1:0] xfer_rtile;
  logic [`DMA_RADDR_WIDTH-1:0] xfer_raddr;
  logic                        xfer_dir;
  logic                        xfer_stall;
  logic                        stall_on;

  // Model of the table contents and of transfers in expected service order
  dma_request_t shadow [`DMA_TABLE_ENTRIES];
  dma_request_t exp_q [$];
  int unsigned  beat_idx;
  logic         hold_pending;
  beat_t        held;

  dma_ctrl_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .haddr      (haddr),
    .hwdata     (hwdata),
    .hsel       (hsel),
    .hmastlock  (hmastlock),
    .hwrite     (hwrite),
    .hrdata     (hrdata),
    .hready     (hready),
    .xfer_valid (xfer_valid),
    .xfer_laddr (xfer_laddr),
    .xfer_rtile (xfer_rtile),
    .xfer_raddr (xfer_raddr),
    .xfer_dir   (xfer_dir),
    .xfer_stall (xfer_stall)
  );

  always #CLK_HALF clk = ~clk;

  // Random back-pressure changed just after each edge
  always @(posedge clk) begin
    #1;
    if (stall_on) begin
      xfer_stall = 1'($urandom_range(1, 0));
    end else begin
      xfer_stall = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("Mismatch at %0t ns: %s", $time, what));
  endtask

  // Beat k steps both addresses by one word and copies tile and direction
  function automatic beat_t beat_ref(input dma_request_t d, input int unsigned k);
    beat_t b;
    b.laddr = d.laddr + `DMA_LADDR_WIDTH'(BEAT_STEP * k);
    b.rtile = d.rtile;
    b.raddr = d.raddr + `DMA_RADDR_WIDTH'(BEAT_STEP * k);
    b.dir   = d.dir;
    return b;
  endfunction

  // Checks every consumed beat and every stalled cycle
  always @(posedge clk) begin
    beat_t got;
    beat_t want;
    got = {xfer_laddr, xfer_rtile, xfer_raddr, xfer_dir};
    if (!rst_n) begin
      hold_pending = 1'b0;
      beat_idx     = 0;
    end else begin
      // Beat offered under stall must still be there unchanged
      if (hold_pending) begin
        assert (xfer_valid && got == held)
          else report_mismatch($sformatf("stalled beat changed from %h to %h", held, got));
      end
      if (xfer_valid && !xfer_stall) begin
        assert (exp_q.size() > 0)
          else stop_run("A beat came out with no posted transfer pending");
        want = beat_ref(exp_q[0], beat_idx);
        assert (got == want)
          else report_mismatch($sformatf("beat %0d got %h expected %h", beat_idx, got, want));
        beat_idx++;
        if (beat_idx == 32'(exp_q[0].size)) begin
          void'(exp_q.pop_front());
          beat_idx = 0;
        end
      end
      hold_pending = xfer_valid && xfer_stall;
      held         = got;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register port tasks entered just after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic bus_idle();
    hsel      = 1'b0;
    hmastlock = 1'b0;
    hwrite    = 1'b0;
    haddr     = '0;
    hwdata    = '0;
  endtask

  // Entry window of 32 bytes with one word per 4 bytes
  function automatic logic [`DMA_ADDR_WIDTH-1:0] reg_addr(input int unsigned pos,
                                                         input int unsigned word);
    return `DMA_ADDR_WIDTH'(pos * 32 + word * 4);
  endfunction

  task automatic bus_write(input int unsigned pos, input int unsigned word,
                           input logic [31:0] data);
    haddr     = reg_addr(pos, word);
    hwdata    = data;
    hsel      = 1'b1;
    hmastlock = 1'b1;
    hwrite    = 1'b1;
    // Narrow fields keep only the low bits
    case (word)
      0:       shadow[pos].laddr = data;
      1:       shadow[pos].size  = data[15:0];
      2:       shadow[pos].rtile = data[7:0];
      3:       shadow[pos].raddr = data;
      4:       shadow[pos].dir   = data[0];
      default: ;
    endcase
    @(posedge clk);
    #1;
    bus_idle();
  endtask

  task automatic status_read(input int unsigned pos, output logic [31:0] data);
    haddr     = reg_addr(pos, STATUS_WORD);
    hsel      = 1'b1;
    hmastlock = 1'b1;
    hwrite    = 1'b0;
    @(negedge clk);
    assert (hready)
      else report_mismatch("hready low during a qualified status read");
    data = hrdata;
    @(posedge clk);
    #1;
    bus_idle();
  endtask

  task automatic check_status(input int unsigned pos, input logic [31:0] want);
    logic [31:0] rd;
    status_read(pos, rd);
    assert (rd == want)
      else report_mismatch($sformatf("status of entry %0d read %h expected %h", pos, rd, want));
  endtask

  // Upper bits junk so that truncation is exercised
  task automatic write_desc(input int unsigned pos, input dma_request_t d);
    logic [15:0] junk;
    junk = 16'($urandom());
    bus_write(pos, 0, d.laddr);
    bus_write(pos, 1, {junk, d.size});
    bus_write(pos, 2, {junk, junk[7:0], d.rtile});
    bus_write(pos, 3, d.raddr);
    bus_write(pos, 4, {junk, junk[14:0], d.dir});
  endtask

  // Size zero gives no beats and adds nothing to expect
  task automatic expect_entry(input int unsigned pos);
    if (shadow[pos].size != '0) begin
      exp_q.push_back(shadow[pos]);
    end
  endtask

  task automatic post_entry(input int unsigned pos);
    bus_write(pos, STATUS_WORD, $urandom());
  endtask

  // Poll status until done and acknowledge it on the way
  task automatic wait_done(input int unsigned pos);
    logic [31:0] rd;
    int unsigned tries;
    rd    = '0;
    tries = 0;
    while (rd[0] !== 1'b1) begin
      if (tries == DONE_TIMEOUT) begin
        stop_run($sformatf("Timed out waiting for entry %0d to finish", pos));
      end else begin
        status_read(pos, rd);
        assert (rd[31:1] == '0)
          else report_mismatch($sformatf("status upper bits set, read %h", rd));
        tries++;
      end
    end
  endtask

  function automatic dma_request_t rand_desc(input int unsigned size);
    dma_request_t d;
    d.laddr = $urandom() & 32'hffff_fffc;
    d.size  = 16'(size);
    d.rtile = 8'($urandom());
    d.raddr = $urandom() & 32'hffff_fffc;
    d.dir   = 1'($urandom());
    return d;
  endfunction

  task automatic check_drained(input string where);
    assert (exp_q.size() == 0)
      else report_mismatch($sformatf("%0d transfers left after %s", exp_q.size(), where));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h5f0b194c));
    clk        = 1'b0;
    rst_n      = 1'b0;
    stall_on   = 1'b0;
    xfer_stall = 1'b0;
    bus_idle();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Nothing running and nothing done after reset
    assert (!xfer_valid)
      else report_mismatch("xfer_valid high after reset");
    for (int p = 0; p < `DMA_TABLE_ENTRIES; p++) begin
      check_status(p, 32'd0);
    end

    // Entry 1 holds real words so a stray post would stream beats
    write_desc(1, rand_desc(3));

    // hready truth table where unqualified status writes must not post
    for (int c = 0; c < 4; c++) begin
      haddr     = reg_addr(1, STATUS_WORD);
      hsel      = c[0];
      hmastlock = c[1];
      hwrite    = ~(c[0] & c[1]);
      @(negedge clk);
      assert (hready == (c[0] & c[1]))
        else report_mismatch($sformatf("hready %b with hsel %b hmastlock %b",
                                       hready, c[0], c[1]));
      @(posedge clk);
      #1;
      bus_idle();
    end
    check_status(1, 32'd0);

    // Single transfer without stall where done reads back once
    write_desc(0, rand_desc(5));
    expect_entry(0);
    post_entry(0);
    wait_done(0);
    check_status(0, 32'd0);
    check_drained("single transfer");

    // Longer transfer under random stall
    stall_on = 1'b1;
    write_desc(3, rand_desc(12));
    expect_entry(3);
    post_entry(3);
    wait_done(3);
    check_drained("stalled transfer");

    // All four entries served from entry 0 upward
    for (int p = 0; p < `DMA_TABLE_ENTRIES; p++) begin
      write_desc(p, rand_desc($urandom_range(6, 1)));
    end
    for (int p = 0; p < `DMA_TABLE_ENTRIES; p++) begin
      expect_entry(p);
    end
    for (int p = 0; p < `DMA_TABLE_ENTRIES; p++) begin
      post_entry(p);
    end
    for (int p = 0; p < `DMA_TABLE_ENTRIES; p++) begin
      wait_done(p);
    end
    check_drained("four entry batch");

    // Entry 1 busy while 0 and 2 are posted
    // Search resumes after 1 so 2 goes before 0
    write_desc(0, rand_desc($urandom_range(6, 1)));
    write_desc(2, rand_desc($urandom_range(6, 1)));
    write_desc(1, rand_desc(10));
    expect_entry(1);
    expect_entry(2);
    expect_entry(0);
    post_entry(1);
    post_entry(0);
    post_entry(2);
    wait_done(1);
    wait_done(2);
    wait_done(0);
    check_drained("round-robin resume");

    // Size zero finishes with no beats
    write_desc(2, rand_desc(0));
    post_entry(2);
    wait_done(2);
    check_status(2, 32'd0);

    // Partial rewrite keeps the old tile and direction
    bus_write(2, 0, $urandom() & 32'hffff_fffc);
    bus_write(2, 1, 32'h5a5a_0004);
    bus_write(2, 3, $urandom() & 32'hffff_fffc);
    expect_entry(2);
    post_entry(2);
    wait_done(2);

    stall_on = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    if (exp_q.size() != 0 || xfer_valid) begin
      stop_run("Transfers still pending at the end of the run");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/dma_pkg.sv
source/dma_bus_if.sv
source/dma_request_table.sv
source/dma_transfer_engine.sv
source/dma_ctrl_top.sv
verif/tb_dma_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the DMA request table testbench
TOP = tb_dma_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module $(TOP) -f vlog.f

# Pass only if the exact pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir
